// ==== Makefile ====
VERILATOR ?= verilator
FLIST     ?= flist.f
TOP       ?= tb_uart_periph
RTL_TOP   ?= uart_periph
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert

.PHONY: lint build sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

# pass only when the simulator prints the pass line
sim: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF '>>> PASS'

clean:
	rm -rf $(OBJ_DIR)

// ==== common/uart_pkg.sv ====
package uart_pkg;

   // serial character and register width
   localparam int DATA_W = 8;

   // register map
   localparam logic [1:0] REG_DATA   = 2'd0;
   localparam logic [1:0] REG_STATUS = 2'd1;
   localparam logic [1:0] REG_CTRL   = 2'd2;

   // status register bits
   localparam int ST_TX_BUSY  = 0;
   localparam int ST_RX_AVAIL = 1;
   localparam int ST_RX_FULL  = 2;
   // sticky, cleared by a status read
   localparam int ST_OVERRUN  = 3;
   localparam int ST_BREAK    = 4;

   // control register bits
   localparam int CTRL_LOOPBACK  = 0;
   localparam int CTRL_RX_IRQ_EN = 1;

endpackage

// ==== flist.f ====
common/uart_pkg.sv
uart/uart_tx.sv
uart/uart_rx.sv
verilog/rx_fifo.sv
verilog/uart_regs.sv
verilog/uart_periph.sv
sim/tb_uart_periph.sv

// ==== sim/tb_uart_periph.sv ====
module tb_uart_periph;
   import uart_pkg::*;

   localparam int CLKS_PER_BIT  = 16;
   localparam int RX_FIFO_DEPTH = 4;
   localparam int CLK_PERIOD    = 8;
   localparam int FRAME_T       = 10 * CLKS_PER_BIT * CLK_PERIOD;
   localparam int NUM_ENTRIES   = 13;
   localparam int TIMEOUT       = NUM_ENTRIES * 12 * FRAME_T + 100 * CLK_PERIOD;
   localparam int POLL_LIMIT    = 12 * CLKS_PER_BIT;

   localparam int M_TX    = 0;
   localparam int M_RX    = 1;
   localparam int M_LOOP  = 2;
   localparam int M_BURST = 3;
   localparam int M_BREAK = 4;

   localparam logic [7:0] S_NONE  = 8'h00;
   localparam logic [7:0] S_AVAIL = 8'(1 << ST_RX_AVAIL);
   localparam logic [7:0] S_FULL  = 8'(1 << ST_RX_FULL);
   localparam logic [7:0] S_OVR   = 8'(1 << ST_OVERRUN);
   localparam logic [7:0] S_BRK   = 8'(1 << ST_BREAK);
   localparam logic [7:0] C_LOOP  = 8'(1 << CTRL_LOOPBACK);
   localparam logic [7:0] C_IRQ   = 8'(1 << CTRL_RX_IRQ_EN);

   logic       clk_i;
   logic       rst_i;
   logic [1:0] addr_i;
   logic       wr_i;
   logic       rd_i;
   logic [7:0] wdata_i;
   logic [7:0] rdata_o;
   logic       rxd_i;
   logic       txd_o;
   logic       irq_o;

   int         mode_tbl [NUM_ENTRIES];
   logic [7:0] data_tbl [NUM_ENTRIES];
   logic [7:0] exp_tbl  [NUM_ENTRIES];
   logic [7:0] burst_q [$];
   logic [7:0] rd_val;
   logic [31:0] rnd;
   bit         burst_end;
   int         errors;
   int         checks;

   uart_periph #(
      .CLKS_PER_BIT  (CLKS_PER_BIT),
      .RX_FIFO_DEPTH (RX_FIFO_DEPTH)
   ) dut_i (
      .clk_i   (clk_i),
      .rst_i   (rst_i),
      .addr_i  (addr_i),
      .wr_i    (wr_i),
      .rd_i    (rd_i),
      .wdata_i (wdata_i),
      .rdata_o (rdata_o),
      .rxd_i   (rxd_i),
      .txd_o   (txd_o),
      .irq_o   (irq_o)
   );

   initial
   begin
      clk_i = 1'b0;
      forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
   end

   initial
   begin
      #(TIMEOUT);
      $display("timeout, the tests did not finish within %0d time units", TIMEOUT);
      $display(">>> FAIL");
      $finish;
   end

   task automatic check(input logic [7:0] actual, input logic [7:0] expected,
                        input string what);
      checks++;
      if (actual !== expected)
      begin
         $display("FAIL @%0t: %s, got %02h expected %02h", $time, what, actual, expected);
         errors++;
      end
   endtask

   task automatic reg_write(input logic [1:0] addr, input logic [7:0] data);
      @(posedge clk_i);
      #1;
      addr_i  = addr;
      wdata_i = data;
      wr_i    = 1'b1;
      @(posedge clk_i);
      #1;
      wr_i = 1'b0;
   endtask

   // read data is registered and valid one cycle after the strobe
   task automatic reg_read(input logic [1:0] addr, output logic [7:0] data);
      @(posedge clk_i);
      #1;
      addr_i = addr;
      rd_i   = 1'b1;
      @(posedge clk_i);
      #1;
      rd_i = 1'b0;
      data = rdata_o;
   endtask

   task automatic wait_status(input int bit_pos, input logic level,
                              output logic [7:0] status);
      int tries;
      tries = 0;
      reg_read(REG_STATUS, status);
      while (status[bit_pos] !== level && tries < POLL_LIMIT)
      begin
         reg_read(REG_STATUS, status);
         tries++;
      end
      if (status[bit_pos] !== level)
      begin
         $display("status bit %0d never went to %0b after %0d polls", bit_pos, level, tries);
         errors++;
      end
   endtask

   // start bit, 8 data bits lsb first and a stop bit at the given level
   task automatic send_frame(input logic [7:0] data, input logic stop_level);
      logic [9:0] bits;
      bits = {stop_level, data, 1'b0};
      for (int i = 0; i < 10; i++)
      begin
         rxd_i = bits[i];
         repeat (CLKS_PER_BIT) @(posedge clk_i);
         #1;
      end
      rxd_i = 1'b1;
   endtask

   // samples on the falling clock so txd_o is settled
   task automatic capture_frame(output logic [7:0] data);
      @(negedge txd_o);
      repeat (CLKS_PER_BIT / 2) @(negedge clk_i);
      check({7'd0, txd_o}, 8'd0, "start bit on txd_o");
      for (int i = 0; i < 8; i++)
      begin
         repeat (CLKS_PER_BIT) @(negedge clk_i);
         data[i] = txd_o;
      end
      repeat (CLKS_PER_BIT) @(negedge clk_i);
      check({7'd0, txd_o}, 8'd1, "stop bit on txd_o");
   endtask

   task automatic run_tx(input logic [7:0] data, input logic [7:0] exp_status);
      logic [7:0] got;
      logic [7:0] status;
      logic [7:0] busy_status;
      wait_status(ST_TX_BUSY, 1'b0, status);
      fork
         capture_frame(got);
         begin
            reg_write(REG_DATA, data);
            reg_read(REG_STATUS, busy_status);
            check({7'd0, busy_status[ST_TX_BUSY]}, 8'd1, "tx busy while sending");
         end
      join
      check(got, data, "byte decoded from txd_o");
      wait_status(ST_TX_BUSY, 1'b0, status);
      check(status, exp_status, "status after transmit");
   endtask

   task automatic run_rx(input logic [7:0] data, input logic [7:0] exp_status);
      logic [7:0] got;
      logic [7:0] status;
      send_frame(data, 1'b1);
      wait_status(ST_RX_AVAIL, 1'b1, status);
      check(status, exp_status, "status after receive");
      check({7'd0, irq_o}, 8'd1, "irq with a byte waiting");
      reg_read(REG_DATA, got);
      check(got, data, "received byte");
      reg_read(REG_STATUS, status);
      check(status, S_NONE, "status after data read");
      check({7'd0, irq_o}, 8'd0, "irq after data read");
   endtask

   task automatic run_loopback(input logic [7:0] data, input logic [7:0] exp_status);
      logic [7:0] got;
      logic [7:0] status;
      // irq stays disabled here
      reg_write(REG_CTRL, C_LOOP);
      // outside line held low and kept away from the receiver
      rxd_i = 1'b0;
      fork
         capture_frame(got);
         reg_write(REG_DATA, data);
      join
      check(got, data, "loopback byte on txd_o");
      wait_status(ST_TX_BUSY, 1'b0, status);
      wait_status(ST_RX_AVAIL, 1'b1, status);
      check(status, exp_status, "status after loopback");
      check({7'd0, irq_o}, 8'd0, "irq with the enable cleared");
      reg_read(REG_DATA, got);
      check(got, data, "loopback byte read back");
      rxd_i = 1'b1;
      reg_write(REG_CTRL, C_IRQ);
   endtask

   task automatic run_break(input logic [7:0] data, input logic [7:0] exp_status);
      logic [7:0] status;
      send_frame(data, 1'b0);
      reg_read(REG_STATUS, status);
      check(status, exp_status, "status after break");
      reg_read(REG_STATUS, status);
      check(status, S_NONE, "break cleared by status read");
      // let the receiver sit out its post break wait
      repeat (2 * CLKS_PER_BIT) @(posedge clk_i);
      #1;
   endtask

   task automatic drain_burst(input logic [7:0] exp_status);
      logic [7:0] got;
      logic [7:0] status;
      reg_read(REG_STATUS, status);
      check(status, exp_status, "status after burst");
      for (int k = 0; k < RX_FIFO_DEPTH; k++)
      begin
         reg_read(REG_DATA, got);
         check(got, burst_q[k], "burst byte order");
      end
      // the fifth byte was dropped so the fifo is empty now
      reg_read(REG_DATA, got);
      check(got, 8'h00, "data read with the fifo empty");
      reg_read(REG_STATUS, status);
      check(status, S_NONE, "overrun cleared by status read");
      burst_q.delete();
   endtask

   task automatic set_entry(input int idx, input int mode, input logic [7:0] data,
                            input logic [7:0] exp_status);
      mode_tbl[idx] = mode;
      data_tbl[idx] = data;
      exp_tbl[idx]  = exp_status;
   endtask

   initial
   begin
      rst_i   = 1'b1;
      addr_i  = 2'd0;
      wr_i    = 1'b0;
      rd_i    = 1'b0;
      wdata_i = 8'h00;
      rxd_i   = 1'b1;
      errors  = 0;
      checks  = 0;
      rnd     = $urandom(32'h0b79_266d);

      set_entry(0, M_TX, 8'ha5, S_NONE);
      set_entry(1, M_TX, 8'h3c, S_NONE);
      set_entry(2, M_RX, 8'h5a, S_AVAIL);
      set_entry(3, M_RX, 8'h81, S_AVAIL);
      // five frames into a four entry fifo
      for (int k = 4; k < 9; k++)
      begin
         rnd = $urandom;
         set_entry(k, M_BURST, rnd[7:0], S_AVAIL | S_FULL | S_OVR);
      end
      set_entry(9, M_BREAK, 8'h00, S_BRK);
      set_entry(10, M_LOOP, 8'hc3, S_AVAIL);
      set_entry(11, M_RX, 8'h7e, S_AVAIL);
      set_entry(12, M_TX, 8'h01, S_NONE);

      repeat (2) @(posedge clk_i);
      #1;
      rst_i = 1'b0;

      check({7'd0, txd_o}, 8'd1, "txd_o after reset");
      check({7'd0, irq_o}, 8'd0, "irq_o after reset");
      reg_read(REG_STATUS, rd_val);
      check(rd_val, S_NONE, "status after reset");
      reg_read(REG_CTRL, rd_val);
      check(rd_val, 8'h00, "control after reset");
      reg_write(REG_CTRL, C_IRQ);
      reg_read(REG_CTRL, rd_val);
      check(rd_val, C_IRQ, "control read back");

      for (int i = 0; i < NUM_ENTRIES; i++)
      begin
         case (mode_tbl[i])
            M_TX:    run_tx(data_tbl[i], exp_tbl[i]);
            M_RX:    run_rx(data_tbl[i], exp_tbl[i]);
            M_LOOP:  run_loopback(data_tbl[i], exp_tbl[i]);
            M_BREAK: run_break(data_tbl[i], exp_tbl[i]);
            default:
            begin
               send_frame(data_tbl[i], 1'b1);
               burst_q.push_back(data_tbl[i]);
               if (i == NUM_ENTRIES - 1)
                  burst_end = 1'b1;
               else
                  burst_end = (mode_tbl[i + 1] != M_BURST);
               if (burst_end)
                  drain_burst(exp_tbl[i]);
            end
         endcase
      end

      $display("checks %0d, errors %0d", checks, errors);
      if (errors == 0)
         $display(">>> PASS");
      else
         $display(">>> FAIL");
      $finish;
   end

endmodule

// ==== uart/uart_rx.sv ====
module uart_rx #(
   parameter int CLKS_PER_BIT = 278
) (
   input  logic                        clk_i,
   input  logic                        rst_i,
   input  logic                        rxd_i,
   output logic [uart_pkg::DATA_W-1:0] data_o,
   output logic                        strobe_o,
   output logic                        break_o
);
   import uart_pkg::*;

   localparam int               CNT_W     = $clog2(CLKS_PER_BIT + 1);
   localparam logic [CNT_W-1:0] FULL_LOAD = CNT_W'(CLKS_PER_BIT - 1);
   localparam logic [CNT_W-1:0] HALF_LOAD = CNT_W'(CLKS_PER_BIT / 2 - 1);
   localparam logic [3:0]       BIT_IDLE  = 4'd0;
   localparam logic [3:0]       BIT_START = 4'd1;
   localparam logic [3:0]       BIT_STOP  = 4'd10;

   logic [1:0]        sync_q;
   logic              rx_s;
   logic [DATA_W-1:0] shift_q;
   logic [3:0]        bit_q;
   logic [CNT_W-1:0]  cnt_q;
   logic              tick;
   logic              sample;
   logic              frame_ok;

   assign rx_s     = sync_q[1];
   assign tick     = (cnt_q == '0);
   assign sample   = tick && (bit_q != BIT_IDLE) && (bit_q != BIT_START) &&
                     (bit_q != BIT_STOP);
   assign frame_ok = tick && (bit_q == BIT_STOP) && rx_s;

   // two flop synchronizer, idles high
   always_ff @(posedge clk_i or posedge rst_i)
   begin
      if (rst_i)
         sync_q <= 2'b11;
      else
         sync_q <= {sync_q[0], rxd_i};
   end

   always_ff @(posedge clk_i)
   begin
      if (sample)
         shift_q <= {rx_s, shift_q[DATA_W-1:1]};
      if (frame_ok)
         data_o <= shift_q;
   end

   always_ff @(posedge clk_i or posedge rst_i)
   begin
      if (rst_i)
      begin
         bit_q    <= BIT_IDLE;
         cnt_q    <= '0;
         strobe_o <= 1'b0;
         break_o  <= 1'b0;
      end
      else
      begin
         strobe_o <= 1'b0;
         break_o  <= 1'b0;

         if (!tick)
            cnt_q <= cnt_q - 1'b1;
         else if (bit_q == BIT_IDLE)
         begin
            // falling edge, wait to the middle of the start bit
            if (!rx_s)
            begin
               cnt_q <= HALF_LOAD;
               bit_q <= BIT_START;
            end
         end
         else if (bit_q == BIT_START)
         begin
            if (!rx_s)
            begin
               cnt_q <= FULL_LOAD;
               bit_q <= bit_q + 4'd1;
            end
            else
               bit_q <= BIT_IDLE;
         end
         else if (bit_q == BIT_STOP)
         begin
            bit_q <= BIT_IDLE;
            if (rx_s)
               strobe_o <= 1'b1;
            else
            begin
               // low stop bit, sit out one bit before looking again
               break_o <= 1'b1;
               cnt_q   <= FULL_LOAD;
            end
         end
         else
         begin
            cnt_q <= FULL_LOAD;
            bit_q <= bit_q + 4'd1;
         end
      end
   end

   strobe_break_excl: assert property (@(posedge clk_i) disable iff (rst_i)
      !(strobe_o && break_o));

endmodule

// ==== uart/uart_tx.sv ====
module uart_tx #(
   parameter int CLKS_PER_BIT = 278
) (
   input  logic                        clk_i,
   input  logic                        rst_i,
   input  logic [uart_pkg::DATA_W-1:0] data_i,
   input  logic                        write_i,
   output logic                        busy_o,
   output logic                        txd_o
);
   import uart_pkg::*;

   localparam int               CNT_W     = $clog2(CLKS_PER_BIT + 1);
   localparam logic [CNT_W-1:0] FULL_LOAD = CNT_W'(CLKS_PER_BIT - 1);
   localparam logic [3:0]       BIT_IDLE  = 4'd0;
   localparam logic [3:0]       BIT_STOP  = 4'd9;

   logic [DATA_W-1:0] buf_q;
   logic              buf_full_q;
   logic [DATA_W-1:0] shift_q;
   logic              shifting_q;
   logic [3:0]        bit_q;
   logic [CNT_W-1:0]  cnt_q;
   logic              tick;
   logic              load;
   logic              shift_en;

   assign tick     = (cnt_q == '0);
   assign load     = tick && (bit_q == BIT_IDLE) && buf_full_q;
   assign shift_en = tick && (bit_q != BIT_IDLE) && (bit_q != BIT_STOP);

   always_ff @(posedge clk_i)
   begin
      if (write_i)
         buf_q <= data_i;
      if (load)
         shift_q <= buf_q;
      else if (shift_en)
         shift_q <= {1'b0, shift_q[DATA_W-1:1]};
   end

   always_ff @(posedge clk_i or posedge rst_i)
   begin
      if (rst_i)
      begin
         buf_full_q <= 1'b0;
         shifting_q <= 1'b0;
         bit_q      <= BIT_IDLE;
         cnt_q      <= '0;
         txd_o      <= 1'b1;
      end
      else
      begin
         if (!tick)
            cnt_q <= cnt_q - 1'b1;
         else if (bit_q == BIT_IDLE)
         begin
            // back to back frames keep shifting set
            shifting_q <= buf_full_q;
            if (buf_full_q)
            begin
               txd_o <= 1'b0;
               bit_q <= 4'd1;
               cnt_q <= FULL_LOAD;
            end
         end
         else if (bit_q == BIT_STOP)
         begin
            txd_o <= 1'b1;
            bit_q <= BIT_IDLE;
            cnt_q <= FULL_LOAD;
         end
         else
         begin
            // data bits, lsb first
            txd_o <= shift_q[0];
            bit_q <= bit_q + 4'd1;
            cnt_q <= FULL_LOAD;
         end

         // a write in the load cycle refills the buffer
         if (write_i)
            buf_full_q <= 1'b1;
         else if (load)
            buf_full_q <= 1'b0;
      end
   end

   assign busy_o = shifting_q | buf_full_q | write_i;

   idle_line_high: assert property (@(posedge clk_i) disable iff (rst_i)
      !shifting_q |-> txd_o);

endmodule

// ==== verilog/rx_fifo.sv ====
module rx_fifo #(
   parameter int RX_FIFO_DEPTH = 4
) (
   input  logic                        clk_i,
   input  logic                        rst_i,
   input  logic                        push_i,
   input  logic [uart_pkg::DATA_W-1:0] push_data_i,
   input  logic                        pop_i,
   output logic [uart_pkg::DATA_W-1:0] pop_data_o,
   output logic                        empty_o,
   output logic                        full_o,
   output logic                        overflow_o
);
   import uart_pkg::*;

   localparam int AW = $clog2(RX_FIFO_DEPTH);

   logic [DATA_W-1:0] mem_q [RX_FIFO_DEPTH];
   logic [AW-1:0]     wr_ptr_q;
   logic [AW-1:0]     rd_ptr_q;
   logic [AW:0]       count_q;
   logic              do_push;

   assign empty_o    = (count_q == '0);
   assign full_o     = (count_q == (AW + 1)'(RX_FIFO_DEPTH));
   // a pop in the same cycle frees the slot
   assign do_push    = push_i && (!full_o || pop_i);
   assign overflow_o = push_i && full_o && !pop_i;
   assign pop_data_o = mem_q[rd_ptr_q];

   always_ff @(posedge clk_i)
   begin
      if (do_push)
         mem_q[wr_ptr_q] <= push_data_i;
   end

   always_ff @(posedge clk_i or posedge rst_i)
   begin
      if (rst_i)
      begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
      end
      else
      begin
         if (do_push)
            wr_ptr_q <= wr_ptr_q + 1'b1;
         if (pop_i)
            rd_ptr_q <= rd_ptr_q + 1'b1;
         case ({do_push, pop_i})
            2'b10:   count_q <= count_q + 1'b1;
            2'b01:   count_q <= count_q - 1'b1;
            default: count_q <= count_q;
         endcase
      end
   end

   no_pop_when_empty: assert property (@(posedge clk_i) disable iff (rst_i)
      pop_i |-> !empty_o);

endmodule

// ==== verilog/uart_periph.sv ====
module uart_periph #(
   parameter int CLKS_PER_BIT  = 278,
   parameter int RX_FIFO_DEPTH = 4
) (
   input  logic                        clk_i,
   input  logic                        rst_i,
   input  logic [1:0]                  addr_i,
   input  logic                        wr_i,
   input  logic                        rd_i,
   input  logic [uart_pkg::DATA_W-1:0] wdata_i,
   output logic [uart_pkg::DATA_W-1:0] rdata_o,
   input  logic                        rxd_i,
   output logic                        txd_o,
   output logic                        irq_o
);
   import uart_pkg::*;

   logic              tx_write;
   logic [DATA_W-1:0] tx_data;
   logic              tx_busy;
   logic              fifo_pop;
   logic [DATA_W-1:0] fifo_data;
   logic              fifo_empty;
   logic              fifo_full;
   logic              overflow;
   logic [DATA_W-1:0] rx_data;
   logic              rx_strobe;
   logic              break_seen;
   logic              loopback;
   logic              rx_line;

   // loopback feeds the transmitter back in, txd_o keeps toggling
   assign rx_line = loopback ? txd_o : rxd_i;

   uart_regs u_regs (
      .clk_i        (clk_i),
      .rst_i        (rst_i),
      .addr_i       (addr_i),
      .wr_i         (wr_i),
      .rd_i         (rd_i),
      .wdata_i      (wdata_i),
      .rdata_o      (rdata_o),
      .tx_write_o   (tx_write),
      .tx_data_o    (tx_data),
      .tx_busy_i    (tx_busy),
      .fifo_pop_o   (fifo_pop),
      .fifo_data_i  (fifo_data),
      .fifo_empty_i (fifo_empty),
      .fifo_full_i  (fifo_full),
      .overflow_i   (overflow),
      .break_i      (break_seen),
      .loopback_o   (loopback),
      .irq_o        (irq_o)
   );

   rx_fifo #(
      .RX_FIFO_DEPTH (RX_FIFO_DEPTH)
   ) u_fifo (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .push_i      (rx_strobe),
      .push_data_i (rx_data),
      .pop_i       (fifo_pop),
      .pop_data_o  (fifo_data),
      .empty_o     (fifo_empty),
      .full_o      (fifo_full),
      .overflow_o  (overflow)
   );

   uart_tx #(
      .CLKS_PER_BIT (CLKS_PER_BIT)
   ) u_tx (
      .clk_i   (clk_i),
      .rst_i   (rst_i),
      .data_i  (tx_data),
      .write_i (tx_write),
      .busy_o  (tx_busy),
      .txd_o   (txd_o)
   );

   uart_rx #(
      .CLKS_PER_BIT (CLKS_PER_BIT)
   ) u_rx (
      .clk_i    (clk_i),
      .rst_i    (rst_i),
      .rxd_i    (rx_line),
      .data_o   (rx_data),
      .strobe_o (rx_strobe),
      .break_o  (break_seen)
   );

endmodule

// ==== verilog/uart_regs.sv ====
module uart_regs (
   input  logic                        clk_i,
   input  logic                        rst_i,
   input  logic [1:0]                  addr_i,
   input  logic                        wr_i,
   input  logic                        rd_i,
   input  logic [uart_pkg::DATA_W-1:0] wdata_i,
   output logic [uart_pkg::DATA_W-1:0] rdata_o,
   output logic                        tx_write_o,
   output logic [uart_pkg::DATA_W-1:0] tx_data_o,
   input  logic                        tx_busy_i,
   output logic                        fifo_pop_o,
   input  logic [uart_pkg::DATA_W-1:0] fifo_data_i,
   input  logic                        fifo_empty_i,
   input  logic                        fifo_full_i,
   input  logic                        overflow_i,
   input  logic                        break_i,
   output logic                        loopback_o,
   output logic                        irq_o
);
   import uart_pkg::*;

   logic              loopback_q;
   logic              irq_en_q;
   logic              overrun_q;
   logic              break_q;
   logic              status_rd;
   logic              ctrl_wr;
   logic [DATA_W-1:0] status_w;
   logic [DATA_W-1:0] ctrl_w;
   logic [DATA_W-1:0] rd_mux;

   assign tx_write_o = wr_i && (addr_i == REG_DATA);
   assign tx_data_o  = wdata_i;
   // empty fifo reads return zero and pop nothing
   assign fifo_pop_o = rd_i && (addr_i == REG_DATA) && !fifo_empty_i;
   assign status_rd  = rd_i && (addr_i == REG_STATUS);
   assign ctrl_wr    = wr_i && (addr_i == REG_CTRL);

   always_comb
   begin
      status_w              = '0;
      status_w[ST_TX_BUSY]  = tx_busy_i;
      status_w[ST_RX_AVAIL] = !fifo_empty_i;
      status_w[ST_RX_FULL]  = fifo_full_i;
      status_w[ST_OVERRUN]  = overrun_q;
      status_w[ST_BREAK]    = break_q;
   end

   always_comb
   begin
      ctrl_w                 = '0;
      ctrl_w[CTRL_LOOPBACK]  = loopback_q;
      ctrl_w[CTRL_RX_IRQ_EN] = irq_en_q;
   end

   always_comb
   begin
      case (addr_i)
         REG_DATA:   rd_mux = fifo_empty_i ? '0 : fifo_data_i;
         REG_STATUS: rd_mux = status_w;
         REG_CTRL:   rd_mux = ctrl_w;
         default:    rd_mux = '0;
      endcase
   end

   always_ff @(posedge clk_i or posedge rst_i)
   begin
      if (rst_i)
      begin
         loopback_q <= 1'b0;
         irq_en_q   <= 1'b0;
         overrun_q  <= 1'b0;
         break_q    <= 1'b0;
         rdata_o    <= '0;
      end
      else
      begin
         if (ctrl_wr)
         begin
            loopback_q <= wdata_i[CTRL_LOOPBACK];
            irq_en_q   <= wdata_i[CTRL_RX_IRQ_EN];
         end

         if (status_rd)
         begin
            overrun_q <= 1'b0;
            break_q   <= 1'b0;
         end
         // events win over the clear
         if (overflow_i)
            overrun_q <= 1'b1;
         if (break_i)
            break_q <= 1'b1;

         if (rd_i)
            rdata_o <= rd_mux;
      end
   end

   assign loopback_o = loopback_q;
   assign irq_o      = irq_en_q && !fifo_empty_i;

   no_wr_rd_overlap: assert property (@(posedge clk_i) disable iff (rst_i)
      !(wr_i && rd_i));

endmodule
